// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_matmul_accel
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation passed
LINTFLAGS ?= --timing
VFLAGS    ?= --timing --assert -Wno-fatal

SOURCES := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
SIMBIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIMBIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIMBIN)
	@out="$$($(SIMBIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/bias_add.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_defs.svh"

module bias_add (
  input  logic            clk,
  input  logic            rst,

  input  logic            res_valid,
  output logic            res_ready,
  input  sa_pkg::y_beat_t res_beat,

  input  logic            a_valid,
  output logic            a_ready,
  input  sa_pkg::a_beat_t a_beat,

  output logic            y_valid,
  input  logic            y_ready,
  output sa_pkg::y_beat_t y_beat
);

  sa_pkg::y_beat_t j_res;
  sa_pkg::a_beat_t j_bias;

  stream_join #(
    .a_t (sa_pkg::y_beat_t),
    .b_t (sa_pkg::a_beat_t)
  ) u_join (
    .clk       (clk),
    .rst       (rst),
    .a_valid   (res_valid),
    .a_ready   (res_ready),
    .a_data    (res_beat),
    .b_valid   (a_valid),
    .b_ready   (a_ready),
    .b_data    (a_beat),
    .out_valid (y_valid),
    .out_ready (y_ready),
    .out_a     (j_res),
    .out_b     (j_bias)
  );

  always_comb begin
    for (int r = 0; r < `SA_R; r++) begin
      // low bits of the bias only, wraps like the accumulator
      y_beat.data[r] = j_res.data[r] + $signed(j_bias.data[r][`SA_WY-1:0]);
    end
    y_beat.last = j_res.last && j_bias.last;
  end

  property p_bias_aligned;
    @(posedge clk) disable iff (rst)
      y_valid && y_ready |-> j_res.last == j_bias.last;
  endproperty
  a_bias_aligned: assert property (p_bias_aligned)
    else $error("bias packet out of step with results");

endmodule

`default_nettype wire

// ==== hw/mac_row.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_defs.svh"

module mac_row (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        advance,
  input  logic                        in_valid,  // product register holds a beat
  input  logic                        first,     // that beat opens a packet
  input  logic signed [`SA_WX-1:0]    x_elem,
  input  sa_pkg::k_vec_t              k_vec,
  output sa_pkg::y_elem_t [`SA_C-1:0] acc
);

  logic signed [`SA_WX+`SA_WK-1:0] prod [`SA_C];

  // product stage, one multiplier per column
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int c = 0; c < `SA_C; c++) begin
        prod[c] <= $signed(x_elem) * $signed(k_vec[c]);
      end
    end
  end

  // accumulate stage
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (advance && in_valid) begin
      for (int c = 0; c < `SA_C; c++) begin
        if (first) begin
          acc[c] <= sa_pkg::y_elem_t'(prod[c]);  // sign extended load
        end else begin
          acc[c] <= acc[c] + prod[c];  // wraps at SA_WY
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/matmul_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_accel_top (
  input  logic            clk,
  input  logic            rst,

  input  logic            k_valid,
  output logic            k_ready,
  input  sa_pkg::k_beat_t k_beat,

  input  logic            x_valid,
  output logic            x_ready,
  input  sa_pkg::x_beat_t x_beat,

  input  logic            a_valid,
  output logic            a_ready,
  input  sa_pkg::a_beat_t a_beat,

  output logic            y_valid,
  input  logic            y_ready,
  output sa_pkg::y_beat_t y_beat
);

  logic            kx_valid;
  logic            kx_ready;
  sa_pkg::k_beat_t kx_k;
  sa_pkg::x_beat_t kx_x;

  logic            res_valid;
  logic            res_ready;
  sa_pkg::y_beat_t res_beat;

  stream_join #(
    .a_t (sa_pkg::k_beat_t),
    .b_t (sa_pkg::x_beat_t)
  ) join_kx (
    .clk       (clk),
    .rst       (rst),
    .a_valid   (k_valid),
    .a_ready   (k_ready),
    .a_data    (k_beat),
    .b_valid   (x_valid),
    .b_ready   (x_ready),
    .b_data    (x_beat),
    .out_valid (kx_valid),
    .out_ready (kx_ready),
    .out_a     (kx_k),
    .out_b     (kx_x)
  );

  systolic_array u_sa (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (kx_valid),
    .in_ready  (kx_ready),
    .in_k      (kx_k),
    .in_x      (kx_x),
    .out_valid (res_valid),
    .out_ready (res_ready),
    .out_beat  (res_beat)
  );

  bias_add u_bias (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_beat  (res_beat),
    .a_valid   (a_valid),
    .a_ready   (a_ready),
    .a_beat    (a_beat),
    .y_valid   (y_valid),
    .y_ready   (y_ready),
    .y_beat    (y_beat)
  );

endmodule

`default_nettype wire

// ==== hw/sa_defs.svh ====
`ifndef SA_DEFS_SVH
`define SA_DEFS_SVH

// array shape
`define SA_R 4  // rows, lanes of x, y and a
`define SA_C 4  // columns, lanes of k and result beats per packet

// element widths
`define SA_WX 8   // activation
`define SA_WK 8   // weight
`define SA_WY 24  // accumulator and result, wraps at this width
`define SA_WA 32  // bias as it arrives, only the low SA_WY bits are used

`endif

// ==== hw/sa_pkg.sv ====
`default_nettype none

`include "sa_defs.svh"

package sa_pkg;

  typedef logic signed [`SA_WX-1:0] x_elem_t;
  typedef logic signed [`SA_WK-1:0] k_elem_t;
  typedef logic signed [`SA_WY-1:0] y_elem_t;
  typedef logic signed [`SA_WA-1:0] a_elem_t;

  typedef x_elem_t [`SA_R-1:0] x_vec_t;  // one column of x
  typedef k_elem_t [`SA_C-1:0] k_vec_t;  // one row of k
  typedef y_elem_t [`SA_R-1:0] y_vec_t;  // one column of sums
  typedef a_elem_t [`SA_R-1:0] a_vec_t;

  typedef struct packed {
    x_vec_t data;
    logic   last;
  } x_beat_t;

  typedef struct packed {
    k_vec_t data;
    logic   last;
  } k_beat_t;

  typedef struct packed {
    a_vec_t data;
    logic   last;
  } a_beat_t;

  typedef struct packed {
    y_vec_t data;
    logic   last;
  } y_beat_t;

endpackage

`default_nettype wire

// ==== hw/stream_join.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_join #(
  parameter type a_t = logic,
  parameter type b_t = logic
) (
  input  logic clk,
  input  logic rst,

  input  logic a_valid,
  output logic a_ready,
  input  a_t   a_data,

  input  logic b_valid,
  output logic b_ready,
  input  b_t   b_data,

  output logic out_valid,
  input  logic out_ready,
  output a_t   out_a,
  output b_t   out_b
);

  logic slot_free;
  logic take;

  assign slot_free = !out_valid || out_ready;  // empty or being emptied

  // each side only moves when the other side is there too
  assign a_ready = slot_free && b_valid;
  assign b_ready = slot_free && a_valid;
  assign take    = slot_free && a_valid && b_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_a <= a_data;
      out_b <= b_data;
    end
  end

  // a stalled pair stays put until the consumer takes it
  property p_hold_on_stall;
    @(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_a) && $stable(out_b);
  endproperty
  a_hold_on_stall: assert property (p_hold_on_stall)
    else $error("stream_join output changed while stalled");

endmodule

`default_nettype wire

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_defs.svh"

module systolic_array (
  input  logic            clk,
  input  logic            rst,

  input  logic            in_valid,
  output logic            in_ready,
  input  sa_pkg::k_beat_t in_k,
  input  sa_pkg::x_beat_t in_x,

  output logic            out_valid,
  input  logic            out_ready,
  output sa_pkg::y_beat_t out_beat
);

  typedef enum logic {
    S_ACC,
    S_DRAIN
  } state_t;

  state_t state;

  logic advance;
  logic accept;
  logic in_last;
  logic first_pend;  // next accepted beat opens a packet
  logic p_valid;
  logic p_first;
  logic p_last;
  logic col_end;
  logic [$clog2(`SA_C)-1:0] col;

  sa_pkg::y_elem_t [`SA_C-1:0] row_acc [`SA_R];

  assign advance = (state == S_ACC);
  // hold off once the last beat sits in the product stage
  assign in_ready = advance && !(p_valid && p_last);
  assign accept   = in_valid && in_ready;
  assign in_last  = in_k.last && in_x.last;
  assign col_end  = (col == ($clog2(`SA_C))'(`SA_C - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      p_valid    <= 1'b0;
      p_first    <= 1'b0;
      p_last     <= 1'b0;
      first_pend <= 1'b1;
    end else if (advance) begin
      p_valid <= accept;
      if (accept) begin
        p_first    <= first_pend;
        p_last     <= in_last;
        first_pend <= in_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_ACC;
      col   <= '0;
    end else begin
      case (state)
        S_ACC: begin
          if (p_valid && p_last) begin  // last beat is being added now
            state <= S_DRAIN;
            col   <= '0;
          end
        end
        S_DRAIN: begin
          if (out_ready) begin
            if (col_end) begin
              state <= S_ACC;
              col   <= '0;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        default: state <= S_ACC;
      endcase
    end
  end

  for (genvar r = 0; r < `SA_R; r++) begin : g_row
    mac_row u_row (
      .clk      (clk),
      .rst      (rst),
      .advance  (advance),
      .in_valid (p_valid),
      .first    (p_first),
      .x_elem   (in_x.data[r]),
      .k_vec    (in_k.data),
      .acc      (row_acc[r])
    );
  end

  // column col of every row
  always_comb begin
    for (int r = 0; r < `SA_R; r++) begin
      out_beat.data[r] = row_acc[r][col];
    end
    out_beat.last = col_end;
  end

  assign out_valid = (state == S_DRAIN);

  property p_last_agree;
    @(posedge clk) disable iff (rst)
      in_valid && in_ready |-> in_k.last == in_x.last;
  endproperty
  a_last_agree: assert property (p_last_agree)
    else $error("k and x last differ on an accepted beat");

  // no new beat may slip in while results leave
  property p_no_accept_in_drain;
    @(posedge clk) disable iff (rst)
      out_valid |-> !in_ready;
  endproperty
  a_no_accept_in_drain: assert property (p_no_accept_in_drain)
    else $error("array ready during drain");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/sa_pkg.sv
hw/stream_join.sv
hw/mac_row.sv
hw/systolic_array.sv
hw/bias_add.sv
hw/matmul_accel_top.sv
testbench/tb_matmul_accel.sv

// ==== testbench/tb_matmul_accel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sa_defs.svh"

module tb_matmul_accel;

  localparam int NPKT = 6;
  localparam int TMAX = 4;
  localparam int WY   = `SA_WY;

  logic            clk;
  logic            rst;
  logic            k_valid;
  logic            k_ready;
  sa_pkg::k_beat_t k_beat;
  logic            x_valid;
  logic            x_ready;
  sa_pkg::x_beat_t x_beat;
  logic            a_valid;
  logic            a_ready;
  sa_pkg::a_beat_t a_beat;
  logic            y_valid;
  logic            y_ready;
  sa_pkg::y_beat_t y_beat;

  int             t_len [NPKT];
  sa_pkg::x_vec_t x_tab [NPKT][TMAX];
  sa_pkg::k_vec_t k_tab [NPKT][TMAX];
  sa_pkg::a_vec_t a_tab [NPKT][`SA_C];
  sa_pkg::y_vec_t y_exp [NPKT][`SA_C];  // one entry per result beat

  integer      seed = 32'he2d0;
  integer      seed_k;
  integer      seed_x;
  integer      seed_a;
  integer      seed_y;
  logic [31:0] rnd_y;
  int          limit = 0;
  int          cycles = 0;
  int          err_cnt = 0;
  int          pkt_pass = 0;
  int          pkt_fail = 0;
  logic        extra = 1'b0;

  matmul_accel_top UUT (
    .clk     (clk),
    .rst     (rst),
    .k_valid (k_valid),
    .k_ready (k_ready),
    .k_beat  (k_beat),
    .x_valid (x_valid),
    .x_ready (x_ready),
    .x_beat  (x_beat),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .a_beat  (a_beat),
    .y_valid (y_valid),
    .y_ready (y_ready),
    .y_beat  (y_beat)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    #1;
    rnd_y   = $random(seed_y);
    y_ready = (rnd_y % 3 != 0);  // low about a third of the time
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [WY-1:0] expected,
                             input logic [WY-1:0] actual);
    if (actual !== expected) begin
      err_cnt++;
      $display("Fail %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic build_table();
    logic [31:0]        rnd;
    logic signed [31:0] acc;
    int                 xv;
    int                 kv;
    int                 bv;
    for (int p = 0; p < NPKT; p++) begin
      rnd = $random(seed);
      t_len[p] = 1 + rnd % TMAX;
      for (int t = 0; t < TMAX; t++) begin
        for (int r = 0; r < `SA_R; r++) begin
          rnd = $random(seed);
          x_tab[p][t][r] = rnd[`SA_WX-1:0];
        end
        for (int c = 0; c < `SA_C; c++) begin
          rnd = $random(seed);
          k_tab[p][t][c] = rnd[`SA_WK-1:0];
        end
      end
      for (int c = 0; c < `SA_C; c++) begin
        for (int r = 0; r < `SA_R; r++) begin
          rnd = $random(seed);
          a_tab[p][c][r] = rnd;  // upper bits random too
        end
      end
    end
    t_len[0] = 1;  // single beat
    t_len[1] = TMAX;
    t_len[2] = 3;
    for (int t = 0; t < TMAX; t++) begin
      for (int i = 0; i < `SA_R; i++) begin
        x_tab[1][t][i] = sa_pkg::x_elem_t'(-128);
        x_tab[2][t][i] = sa_pkg::x_elem_t'(-128);
      end
      for (int i = 0; i < `SA_C; i++) begin
        k_tab[1][t][i] = sa_pkg::k_elem_t'(-128);
        k_tab[2][t][i] = sa_pkg::k_elem_t'(127);
      end
    end
    for (int c = 0; c < `SA_C; c++) begin
      for (int r = 0; r < `SA_R; r++) begin
        a_tab[1][c][r] = 32'ha57fffff;  // max positive low bits, wraps up
        a_tab[2][c][r] = 32'h3c800000;  // most negative, wraps down
      end
    end
    // y[c][r] = sum over t of x[t][r] * k[t][c], plus the signed low bias bits
    for (int p = 0; p < NPKT; p++) begin
      for (int c = 0; c < `SA_C; c++) begin
        for (int r = 0; r < `SA_R; r++) begin
          acc = 0;
          for (int t = 0; t < t_len[p]; t++) begin
            xv  = $signed(x_tab[p][t][r]);
            kv  = $signed(k_tab[p][t][c]);
            acc = acc + xv * kv;
          end
          bv  = $signed(a_tab[p][c][r][`SA_WY-1:0]);
          acc = acc + bv;
          y_exp[p][c][r] = acc[`SA_WY-1:0];
        end
      end
      limit = limit + 16 * (t_len[p] + `SA_C);
    end
    limit = limit + 200;
  endtask

  task automatic feed_k();
    logic [31:0] rnd;
    for (int p = 0; p < NPKT; p++) begin
      for (int t = 0; t < t_len[p]; t++) begin
        rnd     = $random(seed_k);
        k_valid = 1'b0;
        repeat (rnd % 3) begin
          @(posedge clk);
          #1;
        end
        k_beat.data = k_tab[p][t];
        k_beat.last = (t == t_len[p] - 1);
        k_valid     = 1'b1;
        @(negedge clk);
        while (!k_ready) @(negedge clk);
        @(posedge clk);
        #1;
      end
    end
    k_valid = 1'b0;
  endtask

  task automatic feed_x();
    logic [31:0] rnd;
    for (int p = 0; p < NPKT; p++) begin
      for (int t = 0; t < t_len[p]; t++) begin
        rnd     = $random(seed_x);
        x_valid = 1'b0;
        repeat (rnd % 3) begin
          @(posedge clk);
          #1;
        end
        x_beat.data = x_tab[p][t];
        x_beat.last = (t == t_len[p] - 1);
        x_valid     = 1'b1;
        @(negedge clk);
        while (!x_ready) @(negedge clk);
        @(posedge clk);
        #1;
      end
    end
    x_valid = 1'b0;
  endtask

  task automatic feed_a();
    logic [31:0] rnd;
    for (int p = 0; p < NPKT; p++) begin
      for (int c = 0; c < `SA_C; c++) begin
        rnd     = $random(seed_a);
        a_valid = 1'b0;
        repeat (rnd % 4) begin
          @(posedge clk);
          #1;
        end
        a_beat.data = a_tab[p][c];
        a_beat.last = (c == `SA_C - 1);
        a_valid     = 1'b1;
        @(negedge clk);
        while (!a_ready) @(negedge clk);
        @(posedge clk);
        #1;
      end
    end
    a_valid = 1'b0;
  endtask

  task automatic collect_y();
    int errs_before;
    for (int p = 0; p < NPKT; p++) begin
      errs_before = err_cnt;
      for (int c = 0; c < `SA_C; c++) begin
        @(negedge clk);
        while (!(y_valid && y_ready)) @(negedge clk);  // transfer at next edge
        for (int r = 0; r < `SA_R; r++) begin
          check_value($sformatf("y_beat lane %0d", r), y_exp[p][c][r], y_beat.data[r]);
        end
        check_value("y_beat last", WY'(c == `SA_C - 1), WY'(y_beat.last));
      end
      if (err_cnt == errs_before) begin
        pkt_pass++;
        $display("packet %0d (T=%0d): all %0d beats match", p, t_len[p], `SA_C);
      end else begin
        pkt_fail++;
        $display("packet %0d (T=%0d): %0d mismatches", p, t_len[p], err_cnt - errs_before);
      end
    end
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    k_valid = 1'b0;
    x_valid = 1'b0;
    a_valid = 1'b0;
    y_ready = 1'b0;
    k_beat  = '0;
    x_beat  = '0;
    a_beat  = '0;
    seed_k  = seed + 1;
    seed_x  = seed + 2;
    seed_a  = seed + 3;
    seed_y  = seed + 4;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      feed_k();
      feed_x();
      feed_a();
      collect_y();
    join
    repeat (2 * `SA_C + 8) begin
      @(negedge clk);
      if (y_valid) extra = 1'b1;
    end
    if (extra) begin
      err_cnt++;
      $display("y valid was raised again after the last packet had drained");
    end
    $display("%0d packets passed, %0d packets failed", pkt_pass, pkt_fail);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
